// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/icache_pkg.sv
      - logic/itag_memory.sv
      - logic/idata_memory.sv
      - logic/icache_plru.sv
      - logic/icache_ctrl.sv
      - logic/icache_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_clock_gen.sv
      - verification/icache_tb.sv

// File: logic/icache_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_params.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                                             clk_i,
    input  logic                                             rst_n_i,
    input  logic                                             fetch_req_i,
    input  logic [`ICACHE_ADDR_WIDTH-1:0]                    fetch_addr_i,
    output logic                                             fetch_ready_o,
    output logic                                             fetch_valid_o,
    output logic [`ICACHE_DATA_WIDTH-1:0]                    fetch_data_o,
    output logic                                             fetch_err_o,
    input  logic                                             flush_i,
    output logic                                             psel_o,
    output logic                                             penable_o,
    output logic [`ICACHE_ADDR_WIDTH-1:0]                    paddr_o,
    input  logic [`ICACHE_DATA_WIDTH-1:0]                    prdata_i,
    input  logic                                             pready_i,
    input  logic                                             pslverr_i,
    input  logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_WIDTH-1:0]  tag_way_i,
    input  logic [`ICACHE_N_WAY-1:0]                         vbit_i,
    input  logic [`ICACHE_N_WAY-1:0][`ICACHE_DATA_WIDTH-1:0] data_way_i,
    input  way_idx_t                                         victim_way_i,
    output logic [`ICACHE_N_WAY-1:0]                         mem_req_o,
    output logic                                             mem_we_o,
    output logic [`ICACHE_INDEX_BITS-1:0]                    mem_index_o,
    output logic [`ICACHE_TAG_WIDTH-1:0]                     mem_tag_o,
    output logic                                             mem_vbit_o,
    output logic [`ICACHE_DATA_WIDTH-1:0]                    mem_data_o,
    output logic                                             mem_flush_o,
    output logic                                             touch_o,
    output way_idx_t                                         touch_way_o
);

    icache_state_e                  state_q;
    logic [`ICACHE_ADDR_WIDTH-1:0]  addr_q;       // Accepted fetch address
    logic [`ICACHE_DATA_WIDTH-1:0]  resp_data_q;  // Word to return
    logic                           resp_err_q;   // APB slave error seen
    logic                           resp_fill_q;  // Miss, line to be filled
    way_idx_t                       resp_way_q;   // Hit way or fill way
    logic                           flush_pend_q; // Flush waiting for IDLE
    logic                           accept;
    logic                           fill_en;
    logic [`ICACHE_TAG_WIDTH-1:0]   addr_tag;
    logic [`ICACHE_N_WAY-1:0]       hit_vec;
    logic                           hit;
    way_idx_t                       hit_way;
    way_idx_t                       inv_way;
    way_idx_t                       fill_way;
    logic [`ICACHE_N_WAY-1:0]       way_onehot;

    assign addr_tag = addr_q[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];

    // Hit compare against all ways at once
    always_comb begin
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            hit_vec[w] = vbit_i[w] && (tag_way_i[w] == addr_tag);
        end
    end
    assign hit = |hit_vec;

    // Lowest hit way and lowest invalid way, downward scan so lowest wins
    always_comb begin
        hit_way = '0;
        inv_way = '0;
        for (int w = `ICACHE_N_WAY - 1; w >= 0; w--) begin
            if (hit_vec[w]) hit_way = way_idx_t'(w);
            if (!vbit_i[w]) inv_way = way_idx_t'(w);
        end
    end
    assign fill_way = (&vbit_i) ? victim_way_i : inv_way; // Invalid way first

    // Handshake and flush
    assign fetch_ready_o = (state_q == IDLE) && !flush_pend_q && !flush_i;
    assign accept        = fetch_req_i && fetch_ready_o;
    assign mem_flush_o   = (state_q == IDLE) && (flush_i || flush_pend_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            flush_pend_q <= 1'b0;
        end else begin
            flush_pend_q <= !mem_flush_o && (flush_pend_q || flush_i); // Hold until applied
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) addr_q <= fetch_addr_i; // Address stays put for the whole miss
    end

    // Main FSM
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            resp_fill_q <= 1'b0;
            resp_way_q  <= '0;
        end else begin
            unique case (state_q)
                IDLE: begin
                    if (accept) state_q <= LOOKUP; // RAM read issued this cycle
                end
                LOOKUP: begin
                    if (hit) begin
                        resp_data_q <= data_way_i[hit_way];
                        resp_err_q  <= 1'b0;
                        resp_fill_q <= 1'b0;
                        resp_way_q  <= hit_way;
                        state_q     <= RESPOND;
                    end else begin
                        resp_fill_q <= 1'b1;
                        resp_way_q  <= fill_way;     // Victim fixed before refill
                        state_q     <= REFILL_SETUP;
                    end
                end
                REFILL_SETUP: state_q <= REFILL_ACCESS;
                REFILL_ACCESS: begin
                    if (pready_i) begin
                        resp_data_q <= prdata_i;     // Sampled with pready
                        resp_err_q  <= pslverr_i;
                        state_q     <= RESPOND;
                    end
                end
                RESPOND: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // APB read requester
    assign psel_o    = (state_q == REFILL_SETUP) || (state_q == REFILL_ACCESS);
    assign penable_o = (state_q == REFILL_ACCESS);
    assign paddr_o   = {addr_q[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_BITS],
                        {`ICACHE_OFFSET_BITS{1'b0}}}; // Word aligned

    // Fetch response
    assign fetch_valid_o = (state_q == RESPOND);
    assign fetch_data_o  = resp_data_q;
    assign fetch_err_o   = resp_err_q;

    // Fill goes to one way, erroring refills leave the line alone
    always_comb begin
        way_onehot             = '0;
        way_onehot[resp_way_q] = 1'b1;
    end
    assign fill_en = (state_q == RESPOND) && resp_fill_q && !resp_err_q;

    // Read all ways on accept, write the fill way in RESPOND
    assign mem_req_o   = accept ? {`ICACHE_N_WAY{1'b1}} :
                         (fill_en ? way_onehot : '0);
    assign mem_we_o    = fill_en;
    assign mem_index_o = (state_q == IDLE) ?
                         fetch_addr_i[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS] :
                         addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign mem_tag_o   = addr_tag;
    assign mem_vbit_o  = fill_en;
    assign mem_data_o  = resp_data_q;

    // PLRU update on hit and on a good fill
    assign touch_o     = (state_q == RESPOND) && !resp_err_q;
    assign touch_way_o = resp_way_q;

endmodule

`default_nettype wire

// File: logic/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Cache geometry
`define ICACHE_N_WAY        4   // Ways per set
`define ICACHE_DEPTH        64  // Sets per way
`define ICACHE_WAY_BITS     2   // Way number width

// Address split, byte address = {tag, index, offset}
`define ICACHE_ADDR_WIDTH   32  // Byte address width
`define ICACHE_INDEX_BITS   6   // Set index width
`define ICACHE_OFFSET_BITS  2   // Byte offset inside one word
`define ICACHE_TAG_WIDTH    24  // Bits above index and offset

// Line payload
`define ICACHE_DATA_WIDTH   32  // One word per line

`endif

// File: logic/icache_pkg.sv
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,           // Waiting for a fetch or a pending flush
        LOOKUP,         // Tag and data RAM outputs valid, hit compare
        REFILL_SETUP,   // APB setup phase
        REFILL_ACCESS,  // APB access phase, wait for pready
        RESPOND         // Return word, fill and PLRU touch
    } icache_state_e;

    // Way number
    typedef logic [`ICACHE_WAY_BITS-1:0] way_idx_t;

endpackage

`default_nettype wire

// File: logic/icache_plru.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_params.svh"

module icache_plru
    import icache_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [`ICACHE_INDEX_BITS-1:0] index_i,     // Addressed set
    input  logic                          touch_i,     // Access to touch_way_i
    input  way_idx_t                      touch_way_i, // Way just used
    output way_idx_t                      victim_way_o // Replacement candidate
);

    // Tree bits: [0] root, [1] leaf of ways 0/1, [2] leaf of ways 2/3
    logic [2:0] tree_q [0:`ICACHE_DEPTH-1];
    logic [2:0] tree_cur;

    assign tree_cur = tree_q[index_i];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `ICACHE_DEPTH; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch_i) begin
            tree_q[index_i][0] <= ~touch_way_i[1];     // Root points to other pair
            if (touch_way_i[1]) begin
                tree_q[index_i][2] <= ~touch_way_i[0]; // Away inside pair 2/3
            end else begin
                tree_q[index_i][1] <= ~touch_way_i[0]; // Away inside pair 0/1
            end
        end
    end

    // Follow the tree from the root
    assign victim_way_o = {tree_cur[0], tree_cur[0] ? tree_cur[2] : tree_cur[1]};

endmodule

`default_nettype wire

// File: logic/icache_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_params.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          fetch_req_i,
    input  logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr_i,
    output logic                          fetch_ready_o,
    output logic                          fetch_valid_o,
    output logic [`ICACHE_DATA_WIDTH-1:0] fetch_data_o,
    output logic                          fetch_err_o,
    input  logic                          flush_i,
    output logic                          psel_o,
    output logic                          penable_o,
    output logic [`ICACHE_ADDR_WIDTH-1:0] paddr_o,
    input  logic [`ICACHE_DATA_WIDTH-1:0] prdata_i,
    input  logic                          pready_i,
    input  logic                          pslverr_i
);

    logic [`ICACHE_N_WAY-1:0]                         mem_req;    // Way select to both RAMs
    logic                                             mem_we;
    logic [`ICACHE_INDEX_BITS-1:0]                    mem_index;
    logic [`ICACHE_TAG_WIDTH-1:0]                     mem_tag;
    logic                                             mem_vbit;
    logic [`ICACHE_DATA_WIDTH-1:0]                    mem_data;
    logic                                             mem_flush;
    logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_WIDTH-1:0]  tag_way;    // Registered tag per way
    logic [`ICACHE_N_WAY-1:0]                         vbit_way;
    logic [`ICACHE_N_WAY-1:0][`ICACHE_DATA_WIDTH-1:0] data_way;
    logic                                             touch;
    way_idx_t                                         touch_way;
    way_idx_t                                         victim_way;

    icache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .fetch_err_o   (fetch_err_o),
        .flush_i       (flush_i),
        .psel_o        (psel_o),
        .penable_o     (penable_o),
        .paddr_o       (paddr_o),
        .prdata_i      (prdata_i),
        .pready_i      (pready_i),
        .pslverr_i     (pslverr_i),
        .tag_way_i     (tag_way),
        .vbit_i        (vbit_way),
        .data_way_i    (data_way),
        .victim_way_i  (victim_way),
        .mem_req_o     (mem_req),
        .mem_we_o      (mem_we),
        .mem_index_o   (mem_index),
        .mem_tag_o     (mem_tag),
        .mem_vbit_o    (mem_vbit),
        .mem_data_o    (mem_data),
        .mem_flush_o   (mem_flush),
        .touch_o       (touch),
        .touch_way_o   (touch_way)
    );

    itag_memory u_tag_mem (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (mem_req),
        .we_i      (mem_we),
        .vbit_i    (mem_vbit),
        .flush_i   (mem_flush),
        .data_i    (mem_tag),
        .addr_i    (mem_index),
        .tag_way_o (tag_way),
        .vbit_o    (vbit_way)
    );

    idata_memory u_data_mem (
        .clk_i      (clk_i),
        .req_i      (mem_req),
        .we_i       (mem_we),
        .data_i     (mem_data),
        .addr_i     (mem_index),
        .data_way_o (data_way)
    );

    icache_plru u_plru (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .index_i      (mem_index),  // Same set as the RAMs
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .victim_way_o (victim_way)
    );

endmodule

`default_nettype wire

// File: logic/idata_memory.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_params.svh"

module idata_memory (
    input  logic                                             clk_i,
    input  logic [`ICACHE_N_WAY-1:0]                         req_i,      // Way select
    input  logic                                             we_i,       // Write selected ways
    input  logic [`ICACHE_DATA_WIDTH-1:0]                    data_i,     // Refill word
    input  logic [`ICACHE_INDEX_BITS-1:0]                    addr_i,     // Set index
    output logic [`ICACHE_N_WAY-1:0][`ICACHE_DATA_WIDTH-1:0] data_way_o  // One word per way
);

    genvar g_way;
    generate
        for (g_way = 0; g_way < `ICACHE_N_WAY; g_way++) begin : g_data_way
            logic [`ICACHE_DATA_WIDTH-1:0] data_ram [0:`ICACHE_DEPTH-1]; // Word per set

            // Only the selected way is written, contents qualified by tag valid bits
            always_ff @(posedge clk_i) begin
                if (req_i[g_way]) begin
                    if (we_i) begin
                        data_ram[addr_i] <= data_i;            // Fill
                    end else begin
                        data_way_o[g_way] <= data_ram[addr_i]; // Parallel read
                    end
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: logic/itag_memory.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_params.svh"

module itag_memory (
    input  logic                                            clk_i,
    input  logic                                            rst_n_i,
    input  logic [`ICACHE_N_WAY-1:0]                        req_i,     // Way select
    input  logic                                            we_i,      // Write selected ways
    input  logic                                            vbit_i,    // Valid bit to write
    input  logic                                            flush_i,   // Clear all valid bits
    input  logic [`ICACHE_TAG_WIDTH-1:0]                    data_i,    // Tag to write
    input  logic [`ICACHE_INDEX_BITS-1:0]                   addr_i,    // Set index
    output logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_WIDTH-1:0] tag_way_o, // One tag per way
    output logic [`ICACHE_N_WAY-1:0]                        vbit_o     // One valid bit per way
);

    // Valid bits, one vector per way
    logic [`ICACHE_DEPTH-1:0] vbit_vec [0:`ICACHE_N_WAY-1];

    genvar g_way;
    generate
        for (g_way = 0; g_way < `ICACHE_N_WAY; g_way++) begin : g_tag_way
            logic [`ICACHE_TAG_WIDTH-1:0] tag_ram [0:`ICACHE_DEPTH-1]; // Behavioral tag RAM

            // Tag array, write or registered read of the selected way
            always_ff @(posedge clk_i) begin
                if (req_i[g_way]) begin
                    if (we_i) begin
                        tag_ram[addr_i] <= data_i;        // Refill
                    end else begin
                        tag_way_o[g_way] <= tag_ram[addr_i]; // Lookup read
                    end
                end
            end

            // Valid vector, reset and flush clear the whole way
            always_ff @(posedge clk_i) begin
                if (!rst_n_i || flush_i) begin
                    vbit_vec[g_way] <= '0;
                end else if (req_i[g_way] && we_i) begin
                    vbit_vec[g_way][addr_i] <= vbit_i;    // Mark line
                end
            end

            // Registered valid bit, same timing as the tag
            always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                    vbit_o[g_way] <= 1'b0;
                end else if (req_i[g_way] && !we_i) begin
                    vbit_o[g_way] <= vbit_vec[g_way][addr_i];
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/icache_pkg.sv
logic/itag_memory.sv
logic/idata_memory.sv
logic/icache_plru.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verification/tb_clock_gen.sv
verification/icache_tb.sv

// File: verification/icache_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "icache_params.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int N_DIRECTED      = 20;  // Fetches of the directed tests
    localparam int N_RANDOM        = 200;
    localparam int WATCHDOG_CYCLES = 16 + (N_DIRECTED + N_RANDOM) * 20;

    typedef struct packed {
        logic [`ICACHE_ADDR_WIDTH-1:0] addr;
        logic [`ICACHE_DATA_WIDTH-1:0] data;
        logic                          err;
        logic                          hit;
        way_idx_t                      way;  // Way the model hit or filled
    } expect_t;

    logic                          clk;
    logic                          rst_n;
    logic                          fetch_req  = 1'b0;
    logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr = '0;
    logic                          flush      = 1'b0;
    logic [`ICACHE_DATA_WIDTH-1:0] prdata     = '0;
    logic                          pready     = 1'b0;
    logic                          pslverr    = 1'b0;
    logic                          fetch_ready;
    logic                          fetch_valid;
    logic [`ICACHE_DATA_WIDTH-1:0] fetch_data;
    logic                          fetch_err;
    logic                          psel;
    logic                          penable;
    logic [`ICACHE_ADDR_WIDTH-1:0] paddr;
    icache_state_e                 ctrl_state;  // For the timeout report

    // Reference model with one entry per set and way
    logic [`ICACHE_TAG_WIDTH-1:0]  m_tag   [0:`ICACHE_DEPTH-1][0:`ICACHE_N_WAY-1];
    logic                          m_valid [0:`ICACHE_DEPTH-1][0:`ICACHE_N_WAY-1];
    logic [2:0]                    m_tree  [0:`ICACHE_DEPTH-1]; // [0] root, [1] ways 0/1, [2] 2/3

    expect_t                       exp_q [$];          // Predicted responses in order
    logic [15:0]                   lfsr_q       = 16'd91;
    int                            apb_xfers    = 0;   // Setup phases seen
    int                            xfers_seen   = 0;
    int                            cycle_cnt    = 0;
    int                            accept_cycle = 0;
    int                            waits_left   = 0;
    logic [`ICACHE_ADDR_WIDTH-1:0] setup_addr   = '0;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    icache_top u_icache_top (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .fetch_req_i   (fetch_req),
        .fetch_addr_i  (fetch_addr),
        .fetch_ready_o (fetch_ready),
        .fetch_valid_o (fetch_valid),
        .fetch_data_o  (fetch_data),
        .fetch_err_o   (fetch_err),
        .flush_i       (flush),
        .psel_o        (psel),
        .penable_o     (penable),
        .paddr_o       (paddr),
        .prdata_i      (prdata),
        .pready_i      (pready),
        .pslverr_i     (pslverr)
    );

    assign ctrl_state = u_icache_top.u_ctrl.state_q;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            v      = {v[30:0], lfsr_q[0]};  // One step per bit
        end
        return v;
    endfunction

    // Next level memory holds the word address rotated left by 7
    function automatic logic [31:0] apb_word(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {2'b00, addr[31:2]};
        return {word_addr[24:0], word_addr[31:25]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic int plru_victim(input int set);
        if (m_tree[set][0]) return m_tree[set][2] ? 3 : 2;  // Upper pair
        return m_tree[set][1] ? 1 : 0;
    endfunction

    // Steer every tree bit on the path away from the used way
    function automatic void plru_touch(input int set, input int way);
        if (way < 2) begin
            m_tree[set][0] = 1'b1;
            m_tree[set][1] = (way == 0);
        end else begin
            m_tree[set][0] = 1'b0;
            m_tree[set][2] = (way == 2);
        end
    endfunction

    // Predicts one fetch and updates the model as the cache would
    function automatic expect_t predict_fetch(input logic [`ICACHE_ADDR_WIDTH-1:0] addr);
        expect_t                      e;
        int                           set;
        int                           way;
        logic [`ICACHE_TAG_WIDTH-1:0] tag;
        set    = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
        tag    = addr[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
        way    = -1;
        e.addr = addr;
        e.data = apb_word(addr);
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) way = w;
        end
        e.hit = (way >= 0);
        e.err = !e.hit && (addr[31:28] == 4'hF);  // Slave error region
        if (!e.hit) begin
            for (int w = `ICACHE_N_WAY - 1; w >= 0; w--) begin
                if (!m_valid[set][w]) way = w;   // Lowest invalid wins
            end
            if (way < 0) way = plru_victim(set);
        end
        e.way = way_idx_t'(way);
        if (!e.err) begin  // Errors leave line and tree alone
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
            plru_touch(set, way);
        end
        return e;
    endfunction

    task automatic do_fetch(input logic [`ICACHE_ADDR_WIDTH-1:0] addr, output way_idx_t way);
        expect_t e;
        @(posedge clk);
        e = predict_fetch(addr);
        exp_q.push_back(e);
        way        = e.way;
        fetch_req  <= 1'b1;
        fetch_addr <= addr;
        do @(posedge clk); while (!fetch_ready);  // Accepted at this edge
        fetch_req <= 1'b0;
        do @(posedge clk); while (!fetch_valid);
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (int s = 0; s < `ICACHE_DEPTH; s++) begin
            for (int w = 0; w < `ICACHE_N_WAY; w++) m_valid[s][w] = 1'b0;
        end
    endtask

    task automatic apb_answer();
        pready  <= 1'b1;
        prdata  <= apb_word(setup_addr);
        pslverr <= (setup_addr[31:28] == 4'hF);
    endtask

    // APB slave with 0 to 3 random wait states
    always @(posedge clk) begin : apb_slave
        pready  <= 1'b0;
        pslverr <= 1'b0;
        if (rst_n && psel && !penable) begin  // Setup phase
            assert (exp_q.size() != 0) else stop_on_error("APB transfer with no fetch pending");
            assert (paddr == {exp_q[0].addr[31:2], 2'b00}) else stop_on_error($sformatf(
                "ERROR paddr_o: got %h expected %h", paddr, {exp_q[0].addr[31:2], 2'b00}));
            apb_xfers  = apb_xfers + 1;
            setup_addr = paddr;
            waits_left = take_bits(2);
            if (waits_left == 0) apb_answer();
        end else if (rst_n && psel && penable && !pready) begin
            assert (paddr == setup_addr) else stop_on_error($sformatf(
                "ERROR paddr_o: got %h expected %h in access phase", paddr, setup_addr));
            waits_left = waits_left - 1;
            if (waits_left <= 0) apb_answer();
        end
    end

    always @(posedge clk) begin : compare
        expect_t e;
        int      xfers;
        cycle_cnt = cycle_cnt + 1;
        if (rst_n && fetch_req && fetch_ready) accept_cycle = cycle_cnt;
        if (rst_n && fetch_valid) begin
            assert (exp_q.size() != 0) else stop_on_error("Fetch response with no fetch pending");
            e          = exp_q.pop_front();
            xfers      = apb_xfers - xfers_seen;
            xfers_seen = apb_xfers;
            assert (fetch_err === e.err) else stop_on_error($sformatf(
                "ERROR fetch_err_o: got %h expected %h, address %h", fetch_err, e.err, e.addr));
            if (!e.err) begin  // Data only defined without slave error
                assert (fetch_data === e.data) else stop_on_error($sformatf(
                    "ERROR fetch_data_o: got %h expected %h, address %h",
                    fetch_data, e.data, e.addr));
            end
            assert (xfers == (e.hit ? 0 : 1)) else stop_on_error($sformatf(
                "ERROR psel_o transfer count: got %h expected %h, address %h",
                xfers, e.hit ? 0 : 1, e.addr));
            if (e.hit) begin
                assert (cycle_cnt - accept_cycle == 2) else stop_on_error($sformatf(
                    "ERROR fetch_valid_o hit latency: got %h expected %h, address %h",
                    cycle_cnt - accept_cycle, 2, e.addr));
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run not finished after %0d cycles, controller in state %s",
                 WATCHDOG_CYCLES, ctrl_state.name());
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin : stimulus
        logic [`ICACHE_ADDR_WIDTH-1:0] set_addr [0:4];
        way_idx_t                      set_way  [0:4];
        way_idx_t                      way;
        int                            evicted;
        logic [31:0]                   r;
        logic [`ICACHE_ADDR_WIDTH-1:0] addr;
        evicted = 0;
        for (int s = 0; s < `ICACHE_DEPTH; s++) begin
            m_tree[s] = '0;
            for (int w = 0; w < `ICACHE_N_WAY; w++) m_valid[s][w] = 1'b0;
        end
        do @(posedge clk); while (!rst_n);
        assert (fetch_ready === 1'b1) else stop_on_error($sformatf(
            "ERROR fetch_ready_o: got %h expected %h after reset", fetch_ready, 1'b1));
        assert (fetch_valid === 1'b0) else stop_on_error($sformatf(
            "ERROR fetch_valid_o: got %h expected %h after reset", fetch_valid, 1'b0));
        assert (psel === 1'b0) else stop_on_error($sformatf(
            "ERROR psel_o: got %h expected %h after reset", psel, 1'b0));
        assert (penable === 1'b0) else stop_on_error($sformatf(
            "ERROR penable_o: got %h expected %h after reset", penable, 1'b0));

        do_fetch(32'h0000_1236, way);  // Cold miss to an unaligned address
        do_fetch(32'h0000_1236, way);  // Hit
        for (int k = 0; k < 5; k++) begin  // Five tags in set 9
            set_addr[k] = {24'h000100 + 24'(k), 6'd9, 2'b00};
            do_fetch(set_addr[k], set_way[k]);
        end
        for (int k = 0; k < 4; k++) begin
            if (set_way[k] == set_way[4]) evicted = k;  // Line the fifth replaced
        end
        for (int k = 0; k < 5; k++) begin
            if (k != evicted) do_fetch(set_addr[k], way);
        end
        do_fetch(set_addr[evicted], way);  // Refetch of the evicted tag

        pulse_flush();  // Everything misses afterwards
        do_fetch(32'h0000_1236, way);
        for (int k = 0; k < 5; k++) do_fetch(set_addr[k], way);

        do_fetch(32'hF000_0040, way);  // Slave error region is never cached
        do_fetch(32'hF000_0040, way);

        for (int i = 0; i < N_RANDOM; i++) begin
            r = take_bits(16);
            if (r[15:11] == 5'd0) pulse_flush();  // Occasional flush
            addr        = '0;
            addr[31:28] = (r[10:7] == 4'hF) ? 4'hF : 4'h0;
            addr[10:8]  = r[6:4];  // 8 tags over
            addr[3:2]   = r[3:2];  // 4 sets
            addr[1:0]   = r[1:0];
            do_fetch(addr, way);
        end

        @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 10; // 20 ns period
    localparam int RESET_CYCLES = 16; // Reset low this many rising edges

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1; // Released on an edge, seen by the DUT one edge later
    end

endmodule

`default_nettype wire
